// ==== source/glay_kernel_params.svh ====
// ------------------------------
// Build-time sizing for the whole kernel
// Cluster count must stay well below 2**GLAY_VERTEX_W
// ------------------------------

`ifndef GLAY_KERNEL_PARAMS_SVH
`define GLAY_KERNEL_PARAMS_SVH

// Number of graph clusters in the array
`define GLAY_NUM_CLUSTERS 4

// Vertex id and vertex count width
`define GLAY_VERTEX_W 16

// Partial sum and result width, arithmetic wraps at this width
`define GLAY_SUM_W 32

// Cycles each cluster spends in setup after reset
`define GLAY_SETUP_CYCLES 20

// Descriptor bus widths
`define GLAY_DESC_ADDR_W 4
`define GLAY_DESC_DATA_W 32

`endif

// ==== source/glay_control_pkg.sv ====
// ------------------------------
// Control-side types of the kernel sequencer
// ------------------------------

`include "glay_kernel_params.svh"

package glay_control_pkg;

    // Sequencer states, one word each
    typedef enum logic [2:0] {
        CTRL_RESET   = 3'd0,
        CTRL_IDLE    = 3'd1,
        // Waits for start and end of cluster setup
        CTRL_SETUP   = 3'd2,
        CTRL_READY   = 3'd3,
        // Launch strobe goes out here
        CTRL_START   = 3'd4,
        CTRL_BUSY    = 3'd5,
        // Reducer running
        CTRL_COLLECT = 3'd6,
        CTRL_DONE    = 3'd7
    } ctrl_state_t;

    // One bit per cluster
    // Used for the setup and done status vectors
    typedef logic [`GLAY_NUM_CLUSTERS-1:0] cluster_vec_t;

endpackage

// ==== source/glay_descriptor_pkg.sv ====
// ------------------------------
// Run descriptor layout and datapath word types
// ------------------------------

`include "glay_kernel_params.svh"

package glay_descriptor_pkg;

    // Descriptor register addresses
    // Any other address is ignored on write
    typedef enum logic [`GLAY_DESC_ADDR_W-1:0] {
        DESC_VERTEX_COUNT = `GLAY_DESC_ADDR_W'(0),
        DESC_KEY          = `GLAY_DESC_ADDR_W'(1)
    } desc_field_t;

    // Host write data word
    typedef logic [`GLAY_DESC_DATA_W-1:0] desc_data_t;

    // Vertex id, also used for the vertex count
    typedef logic [`GLAY_VERTEX_W-1:0] vertex_t;

    // Partial and final sum, wraps on overflow
    typedef logic [`GLAY_SUM_W-1:0] sum_t;

endpackage

// ==== source/glay_descriptor_regs.sv ====
// ------------------------------
// Host descriptor registers, written only while idle
// Write data above the field width is dropped
// ------------------------------

`timescale 1ns/1ps

`include "glay_kernel_params.svh"

module glay_descriptor_regs (
    input  logic                             ap_clk,
    input  logic                             control_areset,
    input  logic                             desc_write,
    input  glay_descriptor_pkg::desc_field_t desc_addr,
    input  glay_descriptor_pkg::desc_data_t  desc_data,
    input  logic                             ap_idle,
    output glay_descriptor_pkg::vertex_t     vertex_count,
    output glay_descriptor_pkg::vertex_t     key
);

    // Write enable, blocked for the whole run
    logic write_ok;

    // Field value cut from the write data
    glay_descriptor_pkg::vertex_t field_value;

    assign write_ok    = desc_write & ap_idle;
    assign field_value = desc_data[`GLAY_VERTEX_W-1:0];

// ------------------------------
//   Field registers
// ------------------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            vertex_count <= '0;
            key          <= '0;
        end
        else if (write_ok) begin
            case (desc_addr)
                glay_descriptor_pkg::DESC_VERTEX_COUNT: begin
                    vertex_count <= field_value;
                end
                glay_descriptor_pkg::DESC_KEY: begin
                    key <= field_value;
                end
                default: begin
                    // Unknown address, nothing to update
                end
            endcase
        end
    end

endmodule : glay_descriptor_regs

// ==== source/glay_kernel_control.sv ====
// ------------------------------
// ap_ctrl style run sequencer with single-cycle strobes
// Start is held until every cluster has left setup
// ------------------------------

`timescale 1ns/1ps

module glay_kernel_control (
    input  logic                          ap_clk,
    input  logic                          control_areset,
    input  logic                          ap_start,
    input  glay_control_pkg::cluster_vec_t cluster_setup,
    input  glay_control_pkg::cluster_vec_t cluster_done,
    input  logic                          reduce_done,
    output logic                          ap_idle,
    output logic                          ap_ready,
    output logic                          ap_done,
    output logic                          launch,
    output logic                          collect
);

    glay_control_pkg::ctrl_state_t current_state;
    glay_control_pkg::ctrl_state_t next_state;

    // Latched start request
    logic start_pending;

    // Cluster status summaries
    logic setup_clear;
    logic all_done;

    assign setup_clear = ~|cluster_setup;
    assign all_done    = &cluster_done;

// ------------------------------
//   Start request
// ------------------------------

    // Only taken while idle, dropped otherwise
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            start_pending <= 1'b0;
        end
        else if (next_state == glay_control_pkg::CTRL_READY) begin
            start_pending <= 1'b0;
        end
        else if (ap_start & ap_idle) begin
            start_pending <= 1'b1;
        end
    end

// ------------------------------
//   State register
// ------------------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            current_state <= glay_control_pkg::CTRL_RESET;
        end
        else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            glay_control_pkg::CTRL_RESET: begin
                next_state = glay_control_pkg::CTRL_IDLE;
            end
            glay_control_pkg::CTRL_IDLE: begin
                next_state = glay_control_pkg::CTRL_SETUP;
            end
            glay_control_pkg::CTRL_SETUP: begin
                if (start_pending & setup_clear)
                    next_state = glay_control_pkg::CTRL_READY;
            end
            glay_control_pkg::CTRL_READY: begin
                next_state = glay_control_pkg::CTRL_START;
            end
            glay_control_pkg::CTRL_START: begin
                next_state = glay_control_pkg::CTRL_BUSY;
            end
            glay_control_pkg::CTRL_BUSY: begin
                // Done bits were cleared by launch one edge earlier
                if (all_done)
                    next_state = glay_control_pkg::CTRL_COLLECT;
            end
            glay_control_pkg::CTRL_COLLECT: begin
                if (reduce_done)
                    next_state = glay_control_pkg::CTRL_DONE;
            end
            glay_control_pkg::CTRL_DONE: begin
                next_state = glay_control_pkg::CTRL_IDLE;
            end
            default: begin
                next_state = glay_control_pkg::CTRL_RESET;
            end
        endcase
    end

// ------------------------------
//   Output registers
// ------------------------------

    // Registered from the state being entered, so each flag lines up with its state
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            ap_idle  <= 1'b1;
            ap_ready <= 1'b0;
            ap_done  <= 1'b0;
            launch   <= 1'b0;
            collect  <= 1'b0;
        end
        else begin
            ap_idle  <= (next_state == glay_control_pkg::CTRL_RESET) |
                        (next_state == glay_control_pkg::CTRL_IDLE)  |
                        (next_state == glay_control_pkg::CTRL_SETUP) |
                        (next_state == glay_control_pkg::CTRL_DONE);
            ap_ready <= (next_state == glay_control_pkg::CTRL_READY);
            launch   <= (next_state == glay_control_pkg::CTRL_START);
            // One pulse on entry only, the state itself may last longer
            collect  <= (next_state == glay_control_pkg::CTRL_COLLECT) &
                        (current_state != glay_control_pkg::CTRL_COLLECT);
            ap_done  <= (next_state == glay_control_pkg::CTRL_DONE);
        end
    end

endmodule : glay_kernel_control

// ==== source/glay_graph_cluster.sv ====
// ------------------------------
// Stand-in processing element, sums vertex id XOR key
// over its interleaved share of the vertex range
// ------------------------------

`timescale 1ns/1ps

`include "glay_kernel_params.svh"

module glay_graph_cluster #(
    parameter int unsigned CLUSTER_ID = 0
) (
    input  logic                         ap_clk,
    input  logic                         control_areset,
    input  logic                         launch,
    input  glay_descriptor_pkg::vertex_t vertex_count,
    input  glay_descriptor_pkg::vertex_t key,
    output logic                         cluster_setup,
    output logic                         cluster_done,
    output glay_descriptor_pkg::sum_t    partial
);

    localparam int unsigned SETUP_W = $clog2(`GLAY_SETUP_CYCLES + 1);
    // One spare bit so the last step cannot wrap
    localparam int unsigned WALK_W  = `GLAY_VERTEX_W + 1;

    logic [SETUP_W-1:0] setup_count;
    logic               walking;
    logic [WALK_W-1:0]  vertex;
    logic               in_range;

    // Descriptor copy taken at launch
    glay_descriptor_pkg::vertex_t count_q;
    glay_descriptor_pkg::vertex_t key_q;

// ------------------------------
//   Setup countdown
// ------------------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            setup_count <= SETUP_W'(`GLAY_SETUP_CYCLES);
        end
        else if (setup_count != '0) begin
            setup_count <= setup_count - 1'b1;
        end
    end

    assign cluster_setup = (setup_count != '0);

// ------------------------------
//   Vertex walk
// ------------------------------

    assign in_range = (vertex < {1'b0, count_q});

    // Walk ends on the first cycle past the range
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            walking      <= 1'b0;
            cluster_done <= 1'b0;
        end
        else if (launch) begin
            walking      <= 1'b1;
            cluster_done <= 1'b0;
        end
        else if (walking & ~in_range) begin
            walking      <= 1'b0;
            cluster_done <= 1'b1;
        end
    end

    // Datapath
    always_ff @(posedge ap_clk) begin
        if (launch) begin
            vertex  <= WALK_W'(CLUSTER_ID);
            count_q <= vertex_count;
            key_q   <= key;
            partial <= '0;
        end
        else if (walking & in_range) begin
            // Zero-extended XOR term
            partial <= partial + glay_descriptor_pkg::sum_t'(vertex[`GLAY_VERTEX_W-1:0] ^ key_q);
            vertex  <= vertex + WALK_W'(`GLAY_NUM_CLUSTERS);
        end
    end

endmodule : glay_graph_cluster

// ==== source/glay_result_reduce.sv ====
// ------------------------------
// Serial adder over the cluster partials
// Partials must hold still until reduce_done
// ------------------------------

`timescale 1ns/1ps

`include "glay_kernel_params.svh"

module glay_result_reduce (
    input  logic                                                 ap_clk,
    input  logic                                                 control_areset,
    input  logic                                                 collect,
    input  glay_descriptor_pkg::sum_t [`GLAY_NUM_CLUSTERS-1:0] partials,
    output logic                                                 reduce_done,
    output glay_descriptor_pkg::sum_t                            result,
    output logic                                                 result_valid
);

    localparam int unsigned IDX_W = $clog2(`GLAY_NUM_CLUSTERS + 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`GLAY_NUM_CLUSTERS);

    logic             active;
    logic [IDX_W-1:0] idx;

    glay_descriptor_pkg::sum_t acc;

    // Sequencing and result register
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            active       <= 1'b0;
            idx          <= '0;
            reduce_done  <= 1'b0;
            result_valid <= 1'b0;
            result       <= '0;
        end
        else begin
            reduce_done  <= 1'b0;
            result_valid <= 1'b0;
            if (collect) begin
                active <= 1'b1;
                idx    <= IDX_W'(1);
            end
            else if (active) begin
                if (idx == LAST_IDX) begin
                    active       <= 1'b0;
                    reduce_done  <= 1'b1;
                    result_valid <= 1'b1;
                    result       <= acc;
                end
                else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // Accumulator, cluster 0 loads on collect
    always_ff @(posedge ap_clk) begin
        if (collect) begin
            acc <= partials[0];
        end
        else if (active & (idx != LAST_IDX)) begin
            acc <= acc + partials[idx];
        end
    end

endmodule : glay_result_reduce

// ==== source/glay_kernel_top.sv ====
// ------------------------------
// Kernel top, descriptor regs to reducer
// Host strobes carry no back-pressure
// ------------------------------

`timescale 1ns/1ps

`include "glay_kernel_params.svh"

module glay_kernel_top (
    input  logic                             ap_clk,
    input  logic                             control_areset,
    input  logic                             ap_start,
    input  logic                             desc_write,
    input  glay_descriptor_pkg::desc_field_t desc_addr,
    input  glay_descriptor_pkg::desc_data_t  desc_data,
    output logic                             ap_idle,
    output logic                             ap_ready,
    output logic                             ap_done,
    output glay_descriptor_pkg::sum_t        result,
    output logic                             result_valid
);

    // Descriptor fields
    glay_descriptor_pkg::vertex_t vertex_count;
    glay_descriptor_pkg::vertex_t key;

    // Control strobes
    logic launch;
    logic collect;
    logic reduce_done;

    // Cluster status and results
    glay_control_pkg::cluster_vec_t                      cluster_setup;
    glay_control_pkg::cluster_vec_t                      cluster_done;
    glay_descriptor_pkg::sum_t [`GLAY_NUM_CLUSTERS-1:0] partials;

    glay_descriptor_regs u_descriptor_regs (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .desc_write     (desc_write),
        .desc_addr      (desc_addr),
        .desc_data      (desc_data),
        .ap_idle        (ap_idle),
        .vertex_count   (vertex_count),
        .key            (key)
    );

    glay_kernel_control u_kernel_control (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .ap_start       (ap_start),
        .cluster_setup  (cluster_setup),
        .cluster_done   (cluster_done),
        .reduce_done    (reduce_done),
        .ap_idle        (ap_idle),
        .ap_ready       (ap_ready),
        .ap_done        (ap_done),
        .launch         (launch),
        .collect        (collect)
    );

    // Cluster array, one interleave slot each
    for (genvar i = 0; i < `GLAY_NUM_CLUSTERS; i++) begin : g_cluster
        glay_graph_cluster #(
            .CLUSTER_ID (i)
        ) u_graph_cluster (
            .ap_clk         (ap_clk),
            .control_areset (control_areset),
            .launch         (launch),
            .vertex_count   (vertex_count),
            .key            (key),
            .cluster_setup  (cluster_setup[i]),
            .cluster_done   (cluster_done[i]),
            .partial        (partials[i])
        );
    end

    glay_result_reduce u_result_reduce (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .collect        (collect),
        .partials       (partials),
        .reduce_done    (reduce_done),
        .result         (result),
        .result_valid   (result_valid)
    );

endmodule : glay_kernel_top

// ==== test/glay_kernel_tb.sv ====
// ------------------------------
// Self-checking testbench for the kernel top
// Expected sums come from ref_sum, one queue entry per run
// ------------------------------

`timescale 1ns/1ps

`include "glay_kernel_params.svh"

module glay_kernel_tb;

    localparam int unsigned WAIT_LIMIT  = 2000;
    localparam int unsigned RANDOM_RUNS = 30;

    logic                             ap_clk;
    logic                             control_areset;
    logic                             ap_start;
    logic                             desc_write;
    glay_descriptor_pkg::desc_field_t desc_addr;
    glay_descriptor_pkg::desc_data_t  desc_data;
    logic                             ap_idle;
    logic                             ap_ready;
    logic                             ap_done;
    glay_descriptor_pkg::sum_t        result;
    logic                             result_valid;

    // Scoreboard
    glay_descriptor_pkg::sum_t exp_q[$];
    glay_descriptor_pkg::sum_t expected;
    glay_descriptor_pkg::sum_t last_expected;
    logic [31:0]               rng_state;
    int unsigned               errors;
    int unsigned               checks;
    int unsigned               tests_run;
    int unsigned               tests_failed;
    int unsigned               test_errors_at_start;

    // Handshake tracking
    int unsigned done_count;
    int unsigned ready_count;
    int unsigned ready_in_run;
    logic        valid_prev;
    logic        in_run;
    bit          timed_out;

    glay_kernel_top UUT (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .ap_start       (ap_start),
        .desc_write     (desc_write),
        .desc_addr      (desc_addr),
        .desc_data      (desc_data),
        .ap_idle        (ap_idle),
        .ap_ready       (ap_ready),
        .ap_done        (ap_done),
        .result         (result),
        .result_valid   (result_valid)
    );

    // 8 ns period
    always #4 ap_clk = ~ap_clk;

// ------------------------------
//   Reference model
// ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sum of v XOR key for v below count, wraps at 32 bits
    function automatic glay_descriptor_pkg::sum_t ref_sum(
        input int unsigned                  count,
        input glay_descriptor_pkg::vertex_t key
    );
        glay_descriptor_pkg::sum_t    acc;
        glay_descriptor_pkg::vertex_t vid;
        acc = '0;
        for (int unsigned v = 0; v < count; v++) begin
            vid = glay_descriptor_pkg::vertex_t'(v);
            acc = acc + glay_descriptor_pkg::sum_t'(vid ^ key);
        end
        return acc;
    endfunction

// ------------------------------
//   Stimulus tasks
// ------------------------------

    // All tasks start and end 1 ns after a rising edge
    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge ap_clk);
            #1;
        end
    endtask

    task automatic write_desc(input glay_descriptor_pkg::desc_field_t field,
                              input logic [31:0] data);
        desc_write = 1'b1;
        desc_addr  = field;
        desc_data  = data;
        idle_cycles(1);
        desc_write = 1'b0;
    endtask

    task automatic pulse_start();
        ap_start = 1'b1;
        idle_cycles(1);
        ap_start = 1'b0;
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("Timed out waiting for %s, controller stuck in state %s", what,
                 UUT.u_kernel_control.current_state.name());
    endtask

    task automatic wait_for_idle(input logic level, input string what);
        int unsigned cycles;
        cycles = 0;
        if (timed_out)
            return;
        while (ap_idle !== level && cycles < WAIT_LIMIT) begin
            idle_cycles(1);
            cycles++;
        end
        if (ap_idle !== level)
            report_timeout(what);
    endtask

    task automatic wait_for_done(input string what);
        int unsigned cycles;
        cycles = 0;
        if (timed_out)
            return;
        while (ap_done !== 1'b1 && cycles < WAIT_LIMIT) begin
            idle_cycles(1);
            cycles++;
        end
        if (ap_done !== 1'b1)
            report_timeout(what);
    endtask

    // Descriptor writes, expected value, then the start strobe
    task automatic start_run(input logic [31:0] count_word, input logic [31:0] key_word);
        write_desc(glay_descriptor_pkg::DESC_VERTEX_COUNT, count_word);
        write_desc(glay_descriptor_pkg::DESC_KEY, key_word);
        last_expected = ref_sum(count_word[15:0], key_word[15:0]);
        exp_q.push_back(last_expected);
        pulse_start();
    endtask

    task automatic run_once(input logic [31:0] count_word, input logic [31:0] key_word,
                            input string what);
        start_run(count_word, key_word);
        wait_for_done(what);
    endtask

    task automatic end_test(input string name);
        idle_cycles(2);
        tests_run++;
        if (errors == test_errors_at_start) begin
            $display("Test %0d %s: passed", tests_run, name);
        end
        else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_errors_at_start);
        end
    endtask

// ------------------------------
//   Tests
// ------------------------------

    task automatic test_reset_state();
        test_errors_at_start = errors;
        checks++;
        assert (ap_idle === 1'b1 && ap_ready === 1'b0 && ap_done === 1'b0 &&
                result_valid === 1'b0 && result === '0) else begin
            errors++;
            $display("ERROR at %0t: after reset idle=%b ready=%b done=%b valid=%b result=%08h",
                     $time, ap_idle, ap_ready, ap_done, result_valid, result);
        end
        // Start lands while the clusters still count down
        start_run(32'd37, 32'h1234);
        checks++;
        assert (UUT.cluster_setup != '0) else begin
            errors++;
            $display("The start pulse came after cluster setup had already ended");
        end
        wait_for_done("the run started during setup");
        end_test("reset state and start during setup");
    endtask

    task automatic test_single_run();
        test_errors_at_start = errors;
        // Upper key bits are dropped by the registers
        run_once(32'd100, 32'hffff_5a5a, "the fixed run");
        end_test("single fixed run");
    endtask

    task automatic test_random_runs();
        logic [31:0] count_word;
        logic [31:0] key_word;
        int unsigned done_before;
        test_errors_at_start = errors;
        done_before = done_count;
        for (int i = 0; i < RANDOM_RUNS; i++) begin
            rng_state  = xorshift32(rng_state);
            count_word = rng_state % 301;
            rng_state  = xorshift32(rng_state);
            key_word   = {16'h0, rng_state[15:0]};
            run_once(count_word, key_word, "a random run");
        end
        idle_cycles(2);
        checks++;
        assert (done_count - done_before == RANDOM_RUNS) else begin
            errors++;
            $display("Random runs gave %0d ap_done pulses for %0d runs",
                     done_count - done_before, RANDOM_RUNS);
        end
        end_test("random runs");
    endtask

    task automatic test_edge_counts();
        test_errors_at_start = errors;
        for (int n = 0; n < `GLAY_NUM_CLUSTERS; n++) begin
            rng_state = xorshift32(rng_state);
            run_once(n, {16'h0, rng_state[15:0]}, "an edge count run");
            if (n == 0) begin
                idle_cycles(1);
                checks++;
                assert (result === '0) else begin
                    errors++;
                    $display("ERROR at %0t: zero count expected 00000000 observed %08h",
                             $time, result);
                end
            end
        end
        end_test("edge vertex counts");
    endtask

    task automatic test_descriptor_lock();
        test_errors_at_start = errors;
        start_run(32'd150, 32'h0f0f);
        wait_for_idle(1'b0, "the locked run to leave idle");
        // Both writes land mid-run
        write_desc(glay_descriptor_pkg::DESC_VERTEX_COUNT, 32'd7);
        write_desc(glay_descriptor_pkg::DESC_KEY, 32'hffff);
        wait_for_done("the locked run");
        // Unused address, must leave the fields alone
        write_desc(glay_descriptor_pkg::desc_field_t'(`GLAY_DESC_ADDR_W'(5)), 32'd9);
        exp_q.push_back(last_expected);
        pulse_start();
        wait_for_done("the repeated run");
        end_test("descriptor lock");
    endtask

    task automatic test_busy_start();
        int unsigned ready_before;
        int unsigned done_before;
        test_errors_at_start = errors;
        ready_before = ready_count;
        done_before  = done_count;
        start_run(32'd300, 32'h00ff);
        wait_for_idle(1'b0, "the long run to leave idle");
        idle_cycles(5);
        pulse_start();
        wait_for_done("the long run");
        // Long enough for a stray run to show up
        idle_cycles(40);
        checks++;
        assert (done_count - done_before == 1 && ready_count - ready_before == 1) else begin
            errors++;
            $display("A start sent while busy gave %0d ready and %0d done pulses",
                     ready_count - ready_before, done_count - done_before);
        end
        end_test("handshake order and start while busy");
    endtask

// ------------------------------
//   Comparison and handshake monitor
// ------------------------------

    // Falling edge, away from the drive edge
    always @(negedge ap_clk) begin
        if (!control_areset) begin
            checks++;
            assert (ap_done === valid_prev) else begin
                errors++;
                $display("At %0t ap_done did not follow result_valid by one cycle", $time);
            end
            if (ap_done) begin
                done_count++;
                checks++;
                assert (ready_in_run == 1) else begin
                    errors++;
                    $display("At %0t a run ended after %0d ap_ready pulses",
                             $time, ready_in_run);
                end
                ready_in_run = 0;
                in_run       = 1'b0;
            end
            if (ap_ready) begin
                ready_count++;
                ready_in_run++;
                in_run = 1'b1;
                checks++;
                assert (UUT.cluster_setup == '0) else begin
                    errors++;
                    $display("At %0t ap_ready rose with a cluster still in setup", $time);
                end
            end
            if (in_run) begin
                checks++;
                assert (!ap_idle) else begin
                    errors++;
                    $display("At %0t ap_idle was high in the middle of a run", $time);
                end
            end
            if (result_valid) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("At %0t a result arrived with no run pending", $time);
                end
                if (exp_q.size() != 0) begin
                    expected = exp_q.pop_front();
                    checks++;
                    assert (result === expected) else begin
                        errors++;
                        $display("ERROR at %0t: result expected %08h observed %08h",
                                 $time, expected, result);
                    end
                end
            end
            valid_prev = result_valid;
        end
    end

// ------------------------------
//   Main sequence
// ------------------------------

    initial begin
        $timeformat(-9, 0, " ns", 0);
        ap_clk         = 1'b0;
        control_areset = 1'b1;
        ap_start       = 1'b0;
        desc_write     = 1'b0;
        desc_addr      = glay_descriptor_pkg::DESC_VERTEX_COUNT;
        desc_data      = '0;
        rng_state      = 32'hd8de;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        done_count     = 0;
        ready_count    = 0;
        ready_in_run   = 0;
        valid_prev     = 1'b0;
        in_run         = 1'b0;
        timed_out      = 1'b0;

        repeat (16) @(posedge ap_clk);
        #1;
        control_areset = 1'b0;

        test_reset_state();
        if (!timed_out)
            test_single_run();
        if (!timed_out)
            test_random_runs();
        if (!timed_out)
            test_edge_counts();
        if (!timed_out)
            test_descriptor_lock();
        if (!timed_out)
            test_busy_start();

        idle_cycles(4);
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d, timed out %0d",
                 tests_run, tests_failed, checks, errors, timed_out);
        if (errors == 0 && tests_failed == 0 && !timed_out)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule : glay_kernel_tb

// ==== filelist.f ====
+incdir+source
source/glay_control_pkg.sv
source/glay_descriptor_pkg.sv
source/glay_descriptor_regs.sv
source/glay_kernel_control.sv
source/glay_graph_cluster.sv
source/glay_result_reduce.sv
source/glay_kernel_top.sv
test/glay_kernel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the kernel testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module glay_kernel_tb -o sim_glay_kernel
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_glay_kernel)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -Fqx '>>> PASS'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
